// ==== sim.f ====
+incdir+source
source/sad_types_pkg.sv
source/sad_regmap_pkg.sv
source/sad_cfg_if.sv
source/sad_pair_diff.sv
source/sad_registers.sv
source/sad_window_engine.sv
source/sad_trigger_unit.sv
source/sad_x2_top.sv
verif/sad_checker.sv
verif/sad_tb.sv

// ==== Makefile ====
SRCS := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vsad_tb: $(SRCS) sim.f
	verilator --binary --timing --assert -j 0 -f sim.f --top-module sad_tb \
		-Mdir obj_dir -o Vsad_tb

run: obj_dir/Vsad_tb
	./obj_dir/Vsad_tb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/sad_tb.sv ====
`timescale 1ns/1ps
`include "sad_settings.svh"
`default_nettype none

module sad_tb import sad_types_pkg::*, sad_regmap_pkg::*; ();

    localparam int N           = `SAD_REF_SAMPLES;
    localparam int STIM_CYCLES = 14 * 128 + 400;  // bursts plus register traffic
    localparam int CYCLE_LIMIT = STIM_CYCLES + 200;

    logic                         adc_sampleclk;
    logic                         reset;
    sample_t                      adc_datain;
    logic                         armed_and_ready;
    logic                         active;
    logic [7:0]                   reg_address;
    logic [`SAD_BYTECNT_BITS-1:0] reg_bytecnt;
    logic [7:0]                   reg_datai;
    logic [7:0]                   reg_datao;
    logic                         reg_read;
    logic                         reg_write;
    logic                         trigger;
    int                           chk_errors;
    logic                         chk_pending;
    int                           seed = 67732;
    int                           cycles = 0;

    sad_x2_top dut (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .reg_address     (reg_address),
        .reg_bytecnt     (reg_bytecnt),
        .reg_datai       (reg_datai),
        .reg_read        (reg_read),
        .reg_write       (reg_write),
        .reg_datao       (reg_datao),
        .trigger         (trigger)
    );

    sad_checker u_checker (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .reg_address     (reg_address),
        .reg_bytecnt     (reg_bytecnt),
        .reg_datai       (reg_datai),
        .reg_read        (reg_read),
        .reg_write       (reg_write),
        .reg_datao       (reg_datao),
        .trigger         (trigger),
        .errors          (chk_errors),
        .pending         (chk_pending)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #50 adc_sampleclk = ~adc_sampleclk;
    end

    function automatic sample_t ref_value(input int i);
        return sample_t'(16 + 7 * i);  // steep ramp, shifted windows never match
    endfunction

    task automatic send_noise(input int n);
        repeat (n) begin
            @(posedge adc_sampleclk);
            adc_datain <= sample_t'($random(seed));
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input int idx, input logic [7:0] data);
        @(posedge adc_sampleclk);
        adc_datain  <= sample_t'($random(seed));
        reg_address <= addr;
        reg_bytecnt <= `SAD_BYTECNT_BITS'(idx);
        reg_datai   <= data;
        reg_write   <= 1'b1;
        @(posedge adc_sampleclk);
        adc_datain  <= sample_t'($random(seed));
        reg_write   <= 1'b0;
    endtask

    // the checker compares reg_datao while reg_read is high
    task automatic read_reg(input logic [7:0] addr, input int idx);
        @(posedge adc_sampleclk);
        adc_datain  <= sample_t'($random(seed));
        reg_address <= addr;
        reg_bytecnt <= `SAD_BYTECNT_BITS'(idx);
        reg_read    <= 1'b1;
        @(posedge adc_sampleclk);
        adc_datain  <= sample_t'($random(seed));
        reg_read    <= 1'b0;
    endtask

    task automatic read_status();
        for (int b = 0; b < 3; b++)
            read_reg(SAD_STATUS, b);
    endtask

    // warm-up, one embedded pattern with +0/+1 noise, then a gap
    task automatic match_burst(input logic corrupt);
        sample_t s;
        send_noise(N);
        for (int i = 0; i < N; i++) begin
            @(posedge adc_sampleclk);
            s = ref_value(i) + sample_t'($random(seed) & 1);
            if (corrupt && (i == 3 || i == 20))
                s = s ^ 8'h80;  // only at the masked positions
            adc_datain <= s;
        end
        send_noise(2 * N);
    endtask

    initial begin
        reset           = 1'b1;
        adc_datain      = '0;
        armed_and_ready = 1'b0;
        active          = 1'b0;
        reg_address     = '0;
        reg_bytecnt     = '0;
        reg_datai       = '0;
        reg_read        = 1'b0;
        reg_write       = 1'b0;
        repeat (2) @(posedge adc_sampleclk);
        reset <= 1'b0;

        // reset values and readback
        read_status();
        write_reg(SAD_THRESHOLD, 0, 8'h30);
        write_reg(SAD_THRESHOLD, 1, 8'h00);
        for (int i = 0; i < N; i++)
            write_reg(SAD_REFERENCE, i, ref_value(i));
        for (int i = 0; i < N; i++)
            read_reg(SAD_REFERENCE, i);
        for (int i = 0; i < 4; i++) begin
            read_reg(SAD_REFEN, i);
            read_reg(SAD_THRESHOLD, i);
        end
        write_reg(SAD_ALWAYS_ARMED, 0, 8'h01);
        read_reg(SAD_ALWAYS_ARMED, 0);
        read_reg(SAD_MULTIPLE_TRIGGERS, 0);

        // single match, then a corrupted one with full mask
        @(posedge adc_sampleclk);
        active <= 1'b1;
        match_burst(1'b0);
        read_status();
        write_reg(SAD_STATUS, 0, 8'h00);  // unblock one-shot
        match_burst(1'b1);
        read_status();

        // masked positions ignored
        write_reg(SAD_STATUS, 0, 8'h00);
        write_reg(SAD_REFEN, 0, 8'hf7);
        write_reg(SAD_REFEN, 2, 8'hef);
        read_reg(SAD_REFEN, 0);
        read_reg(SAD_REFEN, 2);
        match_burst(1'b1);
        read_status();

        // one-shot versus multiple triggers
        write_reg(SAD_STATUS, 0, 8'h00);
        repeat (3) match_burst(1'b0);
        read_status();
        write_reg(SAD_MULTIPLE_TRIGGERS, 0, 8'h01);
        read_reg(SAD_MULTIPLE_TRIGGERS, 0);
        write_reg(SAD_STATUS, 0, 8'h00);
        repeat (3) match_burst(1'b0);
        read_status();
        write_reg(SAD_STATUS, 0, 8'h00);
        read_status();

        // re-arm clears the status
        write_reg(SAD_ALWAYS_ARMED, 0, 8'h00);
        @(posedge adc_sampleclk);
        armed_and_ready <= 1'b1;
        match_burst(1'b0);
        read_status();
        @(posedge adc_sampleclk);
        armed_and_ready <= 1'b0;
        send_noise(4);
        armed_and_ready <= 1'b1;
        read_status();

        // engine idle while inactive
        @(posedge adc_sampleclk);
        active <= 1'b0;
        repeat (2) match_burst(1'b0);
        read_status();
        send_noise(20);
        @(negedge adc_sampleclk);  // checker done with the last edge

        $display("errors: %0d checker, trigger outstanding at end: %0d", chk_errors, chk_pending);
        if (chk_errors == 0 && !chk_pending) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(posedge adc_sampleclk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, stimulus did not finish", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verif/sad_checker.sv ====
`timescale 1ns/1ps
`include "sad_settings.svh"
`default_nettype none

// watches the DUT ports, predicts triggers and register reads
module sad_checker import sad_regmap_pkg::*; (
    input  wire logic                         adc_sampleclk,
    input  wire logic                         reset,
    input  wire logic [7:0]                   adc_datain,
    input  wire logic                         armed_and_ready,
    input  wire logic                         active,
    input  wire logic [7:0]                   reg_address,
    input  wire logic [`SAD_BYTECNT_BITS-1:0] reg_bytecnt,
    input  wire logic [7:0]                   reg_datai,
    input  wire logic                         reg_read,
    input  wire logic                         reg_write,
    input  wire logic [7:0]                   reg_datao,
    input  wire logic                         trigger,
    output int                                errors,
    output logic                              pending
);

    localparam int N   = `SAD_REF_SAMPLES;
    localparam int LAT = `SAD_TRIGGER_LATENCY_MAX;

    logic [7:0]   ref_q [N];
    logic [7:0]   hist  [N];   // hist[N-1] is the newest sample
    logic [N-1:0] refen_q;
    logic [15:0]  thr_q;
    logic         mt_q;
    logic         aa_q;
    logic [15:0]  count;
    logic         triggered;
    logic         trig_prev;
    logic         armed_prev;
    logic         reset_prev = 1'b1;
    int           filled;
    int           cyc = 0;
    int           earliest;
    int           deadline;

    initial errors = 0;

    // oldest window sample lines up with reference sample 0
    function automatic int window_sad();
        int s;
        int d;
        s = 0;
        for (int i = 0; i < N; i++) begin
            if (refen_q[i]) begin
                d = int'(hist[i]) - int'(ref_q[i]);
                s += (d < 0) ? -d : d;
            end
        end
        return s;
    endfunction

    function automatic logic [7:0] expected_read(input logic [7:0] addr, input int idx);
        logic [31:0] thr_wide;
        thr_wide = {16'h0, thr_q};
        case (addr)
            SAD_STATUS: begin
                if (idx == 0) return {7'b0, triggered};
                if (idx == 1) return count[7:0];
                if (idx == 2) return count[15:8];
                return 8'h00;
            end
            SAD_THRESHOLD:         return (idx < 4) ? thr_wide[idx*8 +: 8] : 8'h00;
            SAD_REFERENCE:         return (idx < N) ? ref_q[idx] : 8'h00;
            SAD_REFEN:             return (idx < N / 8) ? refen_q[idx*8 +: 8] : 8'h00;
            SAD_MULTIPLE_TRIGGERS: return {7'b0, mt_q};
            SAD_ALWAYS_ARMED:      return {7'b0, aa_q};
            default:               return 8'h00;
        endcase
    endfunction

    always @(posedge adc_sampleclk) begin
        cyc++;
        if (reset) begin
            for (int i = 0; i < N; i++)
                ref_q[i] = 8'h00;
            refen_q    = '1;
            thr_q      = '0;
            mt_q       = 1'b0;
            aa_q       = 1'b0;
            count      = '0;
            triggered  = 1'b0;
            trig_prev  = 1'b0;
            armed_prev = 1'b0;
            filled     = 0;
            pending    = 1'b0;
        end else begin
            if (reset_prev && trigger) begin
                $display("trigger is high right after reset");
                errors++;
            end
            if (reg_read && reg_datao !== expected_read(reg_address, int'(reg_bytecnt))) begin
                $display("[FAIL] reg_datao addr %h byte %h: got %h expected %h", reg_address,
                    reg_bytecnt, reg_datao, expected_read(reg_address, int'(reg_bytecnt)));
                errors++;
            end

            if (trigger && !trig_prev) begin
                if (pending && cyc >= earliest) begin
                    pending   = 1'b0;
                    count     = count + 1'b1;
                    triggered = 1'b1;
                end else begin
                    $display("trigger edge at cycle %0d without a matching window", cyc);
                    errors++;
                end
            end
            if (pending && cyc > deadline) begin
                $display("expected trigger edge missing, deadline was cycle %0d", deadline);
                errors++;
                pending = 1'b0;
            end

            if ((armed_and_ready || aa_q) && active) begin
                for (int i = 0; i < N - 1; i++)
                    hist[i] = hist[i+1];
                hist[N-1] = adc_datain;
                filled++;
                if (filled >= N && window_sad() <= int'(thr_q) && !(triggered && !mt_q)) begin
                    pending  = 1'b1;
                    earliest = cyc + 2;        // edge seen one cycle after it is driven
                    deadline = cyc + LAT + 1;
                end
            end else begin
                filled = 0;
            end

            if ((reg_write && reg_address == SAD_STATUS) || (armed_and_ready && !armed_prev)) begin
                count     = '0;
                triggered = 1'b0;
            end
            if (reg_write) begin
                case (reg_address)
                    SAD_REFERENCE: if (int'(reg_bytecnt) < N) ref_q[reg_bytecnt] = reg_datai;
                    SAD_REFEN: begin
                        if (int'(reg_bytecnt) < N / 8)
                            refen_q[int'(reg_bytecnt)*8 +: 8] = reg_datai;
                    end
                    SAD_THRESHOLD: begin
                        if (int'(reg_bytecnt) < 2)
                            thr_q[int'(reg_bytecnt)*8 +: 8] = reg_datai;
                    end
                    SAD_MULTIPLE_TRIGGERS: mt_q = reg_datai[0];
                    SAD_ALWAYS_ARMED:      aa_q = reg_datai[0];
                    default: ;
                endcase
            end
            trig_prev  = trigger;
            armed_prev = armed_and_ready;
        end
        reset_prev = reset;
    end

endmodule

`default_nettype wire

// ==== source/sad_x2_top.sv ====
`timescale 1ns/1ps
`include "sad_settings.svh"
`default_nettype none

module sad_x2_top import sad_types_pkg::*, sad_regmap_pkg::*; (
    input  wire logic                          adc_sampleclk,
    input  wire logic                          reset,
    input  wire sample_t                       adc_datain,
    input  wire logic                          armed_and_ready,
    input  wire logic                          active,
    input  wire logic [7:0]                    reg_address,
    input  wire logic [`SAD_BYTECNT_BITS-1:0]  reg_bytecnt,
    input  wire logic [7:0]                    reg_datai,
    input  wire logic                          reg_read,
    input  wire logic                          reg_write,
    output logic [7:0]                         reg_datao,
    output logic                               trigger
);

    status_u status;
    logic    status_clear;
    logic    multiple_triggers;
    logic    window_hit;

    sad_cfg_if cfg ();

    sad_registers u_registers (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .reg_address       (reg_address),
        .reg_bytecnt       (reg_bytecnt),
        .reg_datai         (reg_datai),
        .reg_read          (reg_read),
        .reg_write         (reg_write),
        .status            (status),
        .reg_datao         (reg_datao),
        .status_clear      (status_clear),
        .multiple_triggers (multiple_triggers),
        .cfg               (cfg.regs)
    );

    sad_window_engine u_window_engine (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .cfg             (cfg.engine),
        .window_hit      (window_hit)
    );

    sad_trigger_unit u_trigger_unit (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .window_hit        (window_hit),
        .armed_and_ready   (armed_and_ready),
        .multiple_triggers (multiple_triggers),
        .status_clear      (status_clear),
        .trigger           (trigger),
        .status            (status)
    );

endmodule

`default_nettype wire

// ==== source/sad_trigger_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module sad_trigger_unit import sad_regmap_pkg::*; (
    input  wire logic adc_sampleclk,
    input  wire logic reset,
    input  wire logic window_hit,
    input  wire logic armed_and_ready,
    input  wire logic multiple_triggers,
    input  wire logic status_clear,
    output logic      trigger,
    output status_u   status
);

    logic        trigger_r;
    logic        armed_r;
    logic [15:0] trig_count;
    logic        triggered;
    logic        trig_rise;
    logic        clear_evt;
    logic        blocked;    // one-shot mode already fired

    assign trig_rise = trigger && !trigger_r;
    assign clear_evt = status_clear || (armed_and_ready && !armed_r);  // host clear or re-arm
    assign blocked   = triggered && !multiple_triggers;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            trigger    <= 1'b0;
            trigger_r  <= 1'b0;
            armed_r    <= 1'b0;
            trig_count <= '0;
            triggered  <= 1'b0;
        end else begin
            trigger   <= window_hit && !blocked;
            trigger_r <= trigger;
            armed_r   <= armed_and_ready;
            if (clear_evt) begin
                trig_count <= '0;
                triggered  <= 1'b0;
            end else if (trig_rise) begin
                trig_count <= trig_count + 1'b1;  // stretched pulse counts once
                triggered  <= 1'b1;
            end
        end
    end

    always_comb begin
        status.fields.count     = trig_count;
        status.fields.reserved  = '0;
        status.fields.triggered = triggered;
    end

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        !(trig_rise || clear_evt) |=> $stable(trig_count));

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        blocked |=> !trigger);

endmodule

`default_nettype wire

// ==== source/sad_window_engine.sv ====
`timescale 1ns/1ps
`include "sad_settings.svh"
`default_nettype none

module sad_window_engine import sad_types_pkg::*; (
    input  wire logic    adc_sampleclk,
    input  wire logic    reset,
    input  wire sample_t adc_datain,
    input  wire logic    armed_and_ready,
    input  wire logic    active,
    sad_cfg_if.engine    cfg,
    output logic         window_hit
);

    localparam int N      = `SAD_REF_SAMPLES;
    localparam int NPAIRS = N / 2;
    localparam int MSB    = `SAD_COUNTER_BITS - 1;

    logic      engine_en;
    pair_idx_t phase_cnt;
    logic      tick;        // pair phase
    pair_idx_t pair_lo;
    pair_idx_t pair_hi;

    sample_t data_a;        // older sample of the pair
    sample_t data_b;

    sample_t ref_a [NPAIRS];
    sample_t ref_b [NPAIRS];
    logic    en_a  [NPAIRS];
    logic    en_b  [NPAIRS];
    sad_t    incr  [NPAIRS];
    sad_t    acc   [N];

    logic [N-1:0] restart;  // one-hot token, marks the accumulator starting a window
    logic [N-1:0] ready;
    logic [N-1:0] hit;

    assign engine_en = (armed_and_ready || cfg.always_armed) && active;
    assign tick      = phase_cnt[0];
    assign pair_lo   = {phase_cnt[$bits(pair_idx_t)-1:1], 1'b0};
    assign pair_hi   = {phase_cnt[$bits(pair_idx_t)-1:1], 1'b1};

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !engine_en) begin
            phase_cnt <= '0;
            restart   <= N'(1) << (N - 3);
            ready     <= '0;
        end else begin
            if (phase_cnt == pair_idx_t'(N - 1))
                phase_cnt <= '0;
            else
                phase_cnt <= phase_cnt + 1'b1;
            restart <= {restart[N-2:0], restart[N-1]};
            ready   <= {ready[N-2:0], ready[0] || (pair_lo == pair_idx_t'(N - 2))};
        end
    end

    // even/odd sample pipeline
    always_ff @(posedge adc_sampleclk) begin
        data_b <= adc_datain;
        data_a <= data_b;
    end

    // reference pairs walk down the chain on the even phase
    always_ff @(posedge adc_sampleclk) begin
        ref_a[0] <= cfg.refs[pair_lo];
        ref_b[0] <= cfg.refs[pair_hi];
        en_a[0]  <= cfg.refen[pair_lo];
        en_b[0]  <= cfg.refen[pair_hi];
        for (int k = 1; k < NPAIRS; k++) begin
            if (!tick) begin
                ref_a[k] <= ref_a[k-1];
                ref_b[k] <= ref_b[k-1];
                en_a[k]  <= en_a[k-1];
                en_b[k]  <= en_b[k-1];
            end
        end
    end

    for (genvar k = 0; k < NPAIRS; k++) begin : g_pair
        sad_pair_diff u_pair_diff (
            .adc_sampleclk (adc_sampleclk),
            .sample_a      (data_a),
            .sample_b      (data_b),
            .ref_a         (ref_a[k]),
            .ref_b         (ref_b[k]),
            .en_a          (en_a[k]),
            .en_b          (en_b[k]),
            .incr          (incr[k])
        );
    end

    // two accumulators share each pair, even ones add on odd phase
    always_ff @(posedge adc_sampleclk) begin
        for (int j = 0; j < N; j++) begin
            if (!engine_en)
                acc[j] <= '0;
            else if (restart[j])
                acc[j] <= incr[j / 2];
            else if ((tick == (j % 2 == 0)) && !acc[j][MSB])
                acc[j] <= acc[j] + incr[j / 2];  // stop once saturated
        end
    end

    // a full window sits in acc[j] in the cycle its token arrives
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            hit <= '0;
        end else begin
            for (int j = 0; j < N; j++)
                hit[j] <= restart[j] && ready[j] && (acc[j] <= cfg.threshold);
        end
    end

    assign window_hit = |hit;

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        engine_en |=> (tick != $past(tick)));

endmodule

`default_nettype wire

// ==== source/sad_registers.sv ====
`timescale 1ns/1ps
`include "sad_settings.svh"
`default_nettype none

module sad_registers import sad_types_pkg::*, sad_regmap_pkg::*; (
    input  wire logic                          adc_sampleclk,
    input  wire logic                          reset,
    input  wire logic [7:0]                    reg_address,
    input  wire logic [`SAD_BYTECNT_BITS-1:0]  reg_bytecnt,
    input  wire logic [7:0]                    reg_datai,
    input  wire logic                          reg_read,
    input  wire logic                          reg_write,
    input  wire status_u                       status,
    output logic [7:0]                         reg_datao,
    output logic                               status_clear,
    output logic                               multiple_triggers,
    sad_cfg_if.regs                            cfg
);

    localparam int REF_BYTES  = `SAD_REF_SAMPLES * `SAD_SAMPLE_BITS / 8;
    localparam int MASK_BYTES = `SAD_REF_SAMPLES / 8;
    localparam int THR_BYTES  = `SAD_COUNTER_BITS / 8;

    logic [`SAD_REF_SAMPLES*`SAD_SAMPLE_BITS-1:0] ref_bits;
    logic [`SAD_REF_SAMPLES-1:0]                  refen_q;
    sad_t                                         threshold_q;
    logic [31:0]                                  threshold_wide;
    logic                                         always_armed_q;

    assign threshold_wide = 32'(threshold_q);  // read back as a 32-bit word

    assign cfg.refs         = ref_bits;
    assign cfg.refen        = refen_q;
    assign cfg.threshold    = threshold_q;
    assign cfg.always_armed = always_armed_q;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ref_bits          <= '0;
            refen_q           <= '1;  // every sample compared
            threshold_q       <= '0;
            multiple_triggers <= 1'b0;
            always_armed_q    <= 1'b0;
            status_clear      <= 1'b0;
        end else begin
            status_clear <= reg_write && (reg_address == SAD_STATUS);
            if (reg_write) begin
                case (sad_reg_e'(reg_address))
                    SAD_REFERENCE: begin
                        if (reg_bytecnt < REF_BYTES)
                            ref_bits[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    SAD_REFEN: begin
                        if (reg_bytecnt < MASK_BYTES)
                            refen_q[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    SAD_THRESHOLD: begin
                        if (reg_bytecnt < THR_BYTES)
                            threshold_q[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    SAD_MULTIPLE_TRIGGERS: multiple_triggers <= reg_datai[0];
                    SAD_ALWAYS_ARMED:      always_armed_q    <= reg_datai[0];
                    default: ;  // status write only clears
                endcase
            end
        end
    end

    // byte-wise read, zero outside a read or past the end of a register
    always_comb begin
        reg_datao = 8'h00;
        if (reg_read) begin
            case (sad_reg_e'(reg_address))
                SAD_REFERENCE: begin
                    if (reg_bytecnt < REF_BYTES)
                        reg_datao = ref_bits[reg_bytecnt*8 +: 8];
                end
                SAD_REFEN: begin
                    if (reg_bytecnt < MASK_BYTES)
                        reg_datao = refen_q[reg_bytecnt*8 +: 8];
                end
                SAD_THRESHOLD: begin
                    if (reg_bytecnt < 4)
                        reg_datao = threshold_wide[reg_bytecnt*8 +: 8];
                end
                SAD_STATUS: begin
                    if (reg_bytecnt < 3)
                        reg_datao = status.bytes[reg_bytecnt[1:0]];
                end
                SAD_MULTIPLE_TRIGGERS: reg_datao = {7'b0, multiple_triggers};
                SAD_ALWAYS_ARMED:      reg_datao = {7'b0, always_armed_q};
                default:               reg_datao = 8'h00;
            endcase
        end
    end

    // host never reads and writes in the same cycle
    assert property (@(posedge adc_sampleclk) disable iff (reset)
        !(reg_read && reg_write));

endmodule

`default_nettype wire

// ==== source/sad_pair_diff.sv ====
`timescale 1ns/1ps
`default_nettype none

// |a - ref_a| + |b - ref_b| for one sample pair, masked per sample
// two register stages, result follows the inputs by two cycles
module sad_pair_diff import sad_types_pkg::*; (
    input  wire logic    adc_sampleclk,
    input  wire sample_t sample_a,
    input  wire sample_t sample_b,
    input  wire sample_t ref_a,
    input  wire sample_t ref_b,
    input  wire logic    en_a,
    input  wire logic    en_b,
    output sad_t         incr
);

    logic    gt_a;
    logic    gt_b;
    sad_t    a_plus;
    sad_t    a_minus;
    sad_t    b_plus;
    sad_t    b_minus;
    sample_t ref_a_q;
    sample_t ref_b_q;
    logic    en_a_q;
    logic    en_b_q;
    sad_t    diff_a;
    sad_t    diff_b;

    // stage 1: compare and widen
    always_ff @(posedge adc_sampleclk) begin
        gt_a    <= sample_a > ref_a;
        gt_b    <= sample_b > ref_b;
        a_plus  <= sad_t'(sample_a);
        a_minus <= -sad_t'(sample_a);
        b_plus  <= sad_t'(sample_b);
        b_minus <= -sad_t'(sample_b);
        ref_a_q <= ref_a;
        ref_b_q <= ref_b;
        en_a_q  <= en_a;
        en_b_q  <= en_b;
    end

    // pick sample - ref or ref - sample from the registered decision
    always_comb begin
        diff_a = gt_a ? (a_plus - sad_t'(ref_a_q)) : (a_minus + sad_t'(ref_a_q));
        diff_b = gt_b ? (b_plus - sad_t'(ref_b_q)) : (b_minus + sad_t'(ref_b_q));
        if (!en_a_q)
            diff_a = '0;
        if (!en_b_q)
            diff_b = '0;
    end

    // stage 2
    always_ff @(posedge adc_sampleclk) begin
        incr <= diff_a + diff_b;
    end

endmodule

`default_nettype wire

// ==== source/sad_cfg_if.sv ====
`timescale 1ns/1ps
`include "sad_settings.svh"
`default_nettype none

// configuration from the register block to the window engine
interface sad_cfg_if import sad_types_pkg::*; ();

    ref_array_t                  refs;
    logic [`SAD_REF_SAMPLES-1:0] refen;      // 1 = sample takes part in the sum
    sad_t                        threshold;
    logic                        always_armed;

    modport regs (
        output refs,
        output refen,
        output threshold,
        output always_armed
    );

    modport engine (
        input refs,
        input refen,
        input threshold,
        input always_armed
    );

endinterface

`default_nettype wire

// ==== source/sad_regmap_pkg.sv ====
`default_nettype none

package sad_regmap_pkg;

    typedef enum logic [7:0] {
        SAD_STATUS            = 8'h00,
        SAD_THRESHOLD         = 8'h01,
        SAD_REFERENCE         = 8'h02,
        SAD_REFEN             = 8'h03,
        SAD_MULTIPLE_TRIGGERS = 8'h04,
        SAD_ALWAYS_ARMED      = 8'h05
    } sad_reg_e;

    typedef struct packed {
        logic [15:0] count;     // trigger rising edges since last clear
        logic [6:0]  reserved;
        logic        triggered;
    } status_fields_t;

    // same 24 bits, seen as fields by the trigger unit
    // and as bytes by the register read mux
    typedef union packed {
        status_fields_t  fields;
        logic [2:0][7:0] bytes;
    } status_u;

endpackage

`default_nettype wire

// ==== source/sad_types_pkg.sv ====
`include "sad_settings.svh"
`default_nettype none

package sad_types_pkg;

    // one adc or reference sample
    typedef logic [`SAD_SAMPLE_BITS-1:0] sample_t;

    // running sum or per-pair increment, saturated when MSB set
    typedef logic [`SAD_COUNTER_BITS-1:0] sad_t;

    typedef sample_t [`SAD_REF_SAMPLES-1:0] ref_array_t;

    // counts 0 .. SAD_REF_SAMPLES-1, bit 0 is the pair phase
    typedef logic [$clog2(`SAD_REF_SAMPLES)-1:0] pair_idx_t;

endpackage

`default_nettype wire

// ==== source/sad_settings.svh ====
`ifndef SAD_SETTINGS_SVH
`define SAD_SETTINGS_SVH
`default_nettype none

`define SAD_REF_SAMPLES          32  // samples in the reference pattern
`define SAD_SAMPLE_BITS          8
`define SAD_COUNTER_BITS         16  // MSB doubles as saturation flag
`define SAD_BYTECNT_BITS         7
`define SAD_TRIGGER_LATENCY_MAX  16  // last window sample to trigger edge

`default_nettype wire
`endif
